//--- wb_subsys.f
+incdir+hw
hw/wb_pkg.sv
hw/wb_stage.sv
hw/gpr_file.sv
hw/commit_tracer.sv
hw/wb_subsys.sv
test/wb_subsys_sva.sv
test/tb_wb_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the write-back testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_wb_subsys -Mdir obj_dir -f wb_subsys.f

status=0
./obj_dir/Vtb_wb_subsys +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

//--- test/tb_wb_subsys.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module tb_wb_subsys
	import wb_pkg::*;
();

	localparam int n_rw = 40;
	localparam int n_stall = 20;
	localparam int n_mem = 40;
	localparam int n_jump = 24; // jal, setup write, jalr per group of three.
	localparam int max_stall = 4;
	// worst case per instruction is capture, stall, commit and trace cycles.
	localparam int max_cycles = 4 + (n_rw + n_stall + n_mem + n_jump) * (max_stall + 4) + 100;

	logic clk = 1'b0;
	logic rst;
	logic valid_mem_wb, ready_mem_wb, advance;
	xlen_t pc_mem_wb, wr_value, raddr, waddr;
	inst_t inst_mem_wb;
	op_class_t op_class_mem_wb;
	reg_idx_t rd_mem_wb, rd_a_idx, rd_b_idx;
	xlen_t rd_a_val, rd_b_val;
	count_t retired_count, load_count, store_count;
	logic jump_valid, mem_valid;
	xlen_t jump_pc, jump_target, mem_addr;
	mem_kind_t mem_kind;

	xlen_t model_regs [`WB_NUM_GPR]; // reference register file.
	int exp_retired, exp_loads, exp_stores;
	int cycles, checks, errors, tests_run, tests_failed;
	int rw_bits [9] = '{`OPC_LUI, `OPC_AUIPC, `OPC_ALUI, `OPC_ALU, `OPC_ALUIW,
		`OPC_ALUW, `OPC_CSR, `OPC_STORE, `OPC_BRANCH};

	wb_subsys dut0 (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > max_cycles) begin
			$display("timeout: run exceeded %0d cycles", max_cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic int total_errors();
		return errors + dut0.sva0.fail_count;
	endfunction

	task automatic check_val(input string what, input xlen_t got, input xlen_t exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// classes that write rd per the RV64 base ISA.
	function automatic bit class_writes(input op_class_t cls);
		return cls[`OPC_LUI] | cls[`OPC_AUIPC] | cls[`OPC_JAL] | cls[`OPC_JALR] |
			cls[`OPC_LOAD] | cls[`OPC_ALUI] | cls[`OPC_ALU] | cls[`OPC_ALUIW] |
			cls[`OPC_ALUW] | cls[`OPC_CSR];
	endfunction

	function automatic inst_t make_inst(input logic [6:0] opcode, input logic [2:0] funct3,
			input reg_idx_t rs1, input reg_idx_t rd, input logic [11:0] imm12);
		return {imm12, rs1, funct3, rd, opcode};
	endfunction

	function automatic inst_t make_jal(input logic [20:0] imm, input reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// one instruction through capture, optional stall, commit and trace.
	task automatic run_instr(input inst_t inst, input op_class_t cls, input reg_idx_t rd,
			input xlen_t value, input xlen_t pc, input int stall, input xlen_t target);
		xlen_t ra;
		xlen_t wa;
		bit is_load;
		bit is_store;
		bit is_jump;
		ra = {$urandom, $urandom};
		wa = {$urandom, $urandom};
		is_load = inst[6:0] == `RV_OP_LOAD && inst[14:12] <= 3'd6;
		is_store = inst[6:0] == `RV_OP_STORE && inst[14:12] <= 3'd3;
		is_jump = cls[`OPC_JAL] | cls[`OPC_JALR];
		valid_mem_wb = 1'b1;
		advance = 1'b1;
		pc_mem_wb = pc;
		inst_mem_wb = inst;
		op_class_mem_wb = cls;
		rd_mem_wb = rd;
		wr_value = value;
		raddr = ra;
		waddr = wa;
		rd_a_idx = rd;
		rd_b_idx = reg_idx_t'($urandom_range(0, 31));
		@(posedge clk);
		#2;
		valid_mem_wb = 1'b0;
		advance = (stall == 0);
		repeat (stall) begin
			@(negedge clk);
			check_val("stalled rd_a", rd_a_val, model_regs[rd]); // old value still there.
			check_val("stalled retired_count", xlen_t'(retired_count), xlen_t'(exp_retired));
			@(posedge clk);
			#2;
		end
		advance = 1'b1;
		if (class_writes(cls) && rd != '0) begin
			model_regs[rd] = value;
		end
		exp_retired++;
		if (is_load) begin
			exp_loads++;
		end
		if (is_store) begin
			exp_stores++;
		end
		@(negedge clk);
		check_val("rd_a", rd_a_val, model_regs[rd]);
		check_val("rd_b", rd_b_val, model_regs[rd_b_idx]);
		@(posedge clk);
		#2;
		@(negedge clk);
		check_val("retired_count", xlen_t'(retired_count), xlen_t'(exp_retired));
		check_val("load_count", xlen_t'(load_count), xlen_t'(exp_loads));
		check_val("store_count", xlen_t'(store_count), xlen_t'(exp_stores));
		check_val("jump_valid", xlen_t'(jump_valid), xlen_t'(is_jump));
		if (is_jump) begin
			check_val("jump_pc", jump_pc, pc);
			check_val("jump_target", jump_target, target);
		end
		check_val("mem_valid", xlen_t'(mem_valid), xlen_t'(is_load | is_store));
		if (is_load) begin
			check_val("load mem_kind", xlen_t'(mem_kind), xlen_t'(MEM_LOAD));
			check_val("load mem_addr", mem_addr, ra);
		end
		if (is_store) begin
			check_val("store mem_kind", xlen_t'(mem_kind), xlen_t'(MEM_STORE));
			check_val("store mem_addr", mem_addr, wa);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic random_alu(input int stall, input bit to_x0);
		int b;
		reg_idx_t rd;
		logic [6:0] opc;
		b = rw_bits[$urandom_range(0, 8)];
		rd = to_x0 ? reg_idx_t'(0) : reg_idx_t'($urandom_range(0, 31));
		opc = (b == `OPC_STORE) ? `RV_OP_STORE : 7'b0110011;
		run_instr(make_inst(opc, 3'($urandom_range(0, 7)), rd, rd, 12'($urandom)),
			op_class_t'(1) << b, rd, {$urandom, $urandom}, {$urandom, $urandom} & ~64'h3,
			stall, '0);
	endtask

	// loads and stores use every funct3, so illegal ones show up too.
	task automatic random_mem();
		int kind;
		int b;
		reg_idx_t rd;
		logic [6:0] opc;
		kind = $urandom_range(0, 2);
		rd = reg_idx_t'($urandom_range(0, 31));
		b = (kind == 0) ? `OPC_LOAD : (kind == 1) ? `OPC_STORE : `OPC_ALU;
		opc = (kind == 0) ? `RV_OP_LOAD : (kind == 1) ? `RV_OP_STORE : 7'b0110011;
		run_instr(make_inst(opc, 3'($urandom_range(0, 7)), rd, rd, 12'($urandom)),
			op_class_t'(1) << b, rd, {$urandom, $urandom}, {$urandom, $urandom} & ~64'h3,
			0, '0);
	endtask

	task automatic jump_group();
		reg_idx_t rs1;
		reg_idx_t rd;
		logic [20:0] jimm;
		logic [11:0] iimm;
		xlen_t pc;
		rs1 = reg_idx_t'($urandom_range(1, 31));
		rd = reg_idx_t'($urandom_range(0, 31));
		jimm = 21'($urandom) & ~21'd1;
		iimm = 12'($urandom);
		pc = {$urandom, $urandom} & ~64'h3;
		run_instr(make_jal(jimm, rd), op_class_t'(1) << `OPC_JAL, rd, pc + 64'd4, pc, 0,
			pc + {{43{jimm[20]}}, jimm});
		// rs1 of the jalr is written by the instruction right before it.
		run_instr(make_inst(7'b0010011, 3'd0, 5'd0, rs1, 12'($urandom)),
			op_class_t'(1) << `OPC_ALUI, rs1, {$urandom, $urandom}, pc + 64'd8, 0, '0);
		pc = {$urandom, $urandom} & ~64'h3;
		run_instr(make_inst(7'b1100111, 3'd0, rs1, rd, iimm), op_class_t'(1) << `OPC_JALR,
			rd, pc + 64'd4, pc, 0, (model_regs[rs1] + {{52{iimm[11]}}, iimm}) & ~64'd1);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (total_errors() == errs_before) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, total_errors() - errs_before);
		end
	endtask

	initial begin
		int e;
		void'($urandom(32'hbc49));
		rst = 1'b1;
		valid_mem_wb = 1'b0;
		advance = 1'b0;
		pc_mem_wb = '0;
		inst_mem_wb = '0;
		op_class_mem_wb = '0;
		rd_mem_wb = '0;
		wr_value = '0;
		raddr = '0;
		waddr = '0;
		rd_a_idx = '0;
		rd_b_idx = '0;
		for (int i = 0; i < `WB_NUM_GPR; i++) begin
			model_regs[i] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		e = total_errors();
		@(negedge clk);
		check_val("reset retired_count", xlen_t'(retired_count), '0);
		check_val("reset load_count", xlen_t'(load_count), '0);
		check_val("reset store_count", xlen_t'(store_count), '0);
		check_val("reset jump_valid", xlen_t'(jump_valid), '0);
		check_val("reset mem_valid", xlen_t'(mem_valid), '0);
		@(posedge clk);
		#2;
		end_test("reset", e);

		e = total_errors();
		for (int i = 0; i < n_rw; i++) begin
			random_alu(0, i % 8 == 0);
		end
		end_test("register write and read", e);

		e = total_errors();
		for (int i = 0; i < n_stall; i++) begin
			random_alu($urandom_range(1, max_stall), 1'b0);
		end
		end_test("stall", e);

		e = total_errors();
		for (int i = 0; i < n_mem; i++) begin
			random_mem();
		end
		end_test("memory trace", e);

		e = total_errors();
		for (int i = 0; i < n_jump / 3; i++) begin
			jump_group();
		end
		end_test("jump trace", e);

		$display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
			tests_run, tests_failed, checks, total_errors());
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- test/wb_subsys_sva.sv
`timescale 1ns/1ps

module wb_subsys_sva (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic wb_valid,
	input logic commit,
	input logic gpr_wen,
	input logic jump_valid,
	input logic mem_valid,
	input logic ready_mem_wb
);

	int fail_count = 0; // summed into the testbench error count.

	commit_needs_valid: assert property (@(posedge clk) disable iff (rst)
		commit |-> (wb_valid && advance))
	else begin
		$error("commit without a valid WB instruction and advance");
		fail_count++;
	end

	// a register write only happens on a retiring instruction.
	wen_needs_commit: assert property (@(posedge clk) disable iff (rst)
		gpr_wen |-> commit)
	else begin
		$error("gpr_wen without commit");
		fail_count++;
	end

	jump_after_commit: assert property (@(posedge clk) disable iff (rst)
		jump_valid |-> $past(commit))
	else begin
		$error("jump_valid not one cycle after a commit");
		fail_count++;
	end

	mem_after_commit: assert property (@(posedge clk) disable iff (rst)
		mem_valid |-> $past(commit))
	else begin
		$error("mem_valid not one cycle after a commit");
		fail_count++;
	end

	ready_always: assert property (@(posedge clk) ready_mem_wb)
	else begin
		$error("ready_mem_wb dropped");
		fail_count++;
	end

endmodule

// wb_valid lives inside the stage.
bind wb_subsys wb_subsys_sva sva0 (
	.clk(clk),
	.rst(rst),
	.advance(advance),
	.wb_valid(stage0.wb_valid),
	.commit(commit),
	.gpr_wen(gpr_wen),
	.jump_valid(jump_valid),
	.mem_valid(mem_valid),
	.ready_mem_wb(ready_mem_wb)
);

//--- hw/wb_subsys.sv
`timescale 1ns/1ps

module wb_subsys
	import wb_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	input  logic      valid_mem_wb,
	output logic      ready_mem_wb,
	input  logic      advance,
	input  xlen_t     pc_mem_wb,
	input  inst_t     inst_mem_wb,
	input  op_class_t op_class_mem_wb,
	input  reg_idx_t  rd_mem_wb,
	input  xlen_t     wr_value,
	input  xlen_t     raddr,
	input  xlen_t     waddr,

	input  reg_idx_t  rd_a_idx,
	input  reg_idx_t  rd_b_idx,
	output xlen_t     rd_a_val,
	output xlen_t     rd_b_val,

	output count_t    retired_count,
	output count_t    load_count,
	output count_t    store_count,
	output logic      jump_valid,
	output xlen_t     jump_pc,
	output xlen_t     jump_target,
	output logic      mem_valid,
	output mem_kind_t mem_kind,
	output xlen_t     mem_addr
);

	logic      commit;
	logic      gpr_wen;
	reg_idx_t  wb_rd;
	xlen_t     wb_wdata;
	xlen_t     wb_pc;
	inst_t     wb_inst;
	op_class_t wb_op_class;
	xlen_t     wb_raddr;
	xlen_t     wb_waddr;
	reg_idx_t  trace_rs1_idx;
	xlen_t     trace_rs1_val;

	assign ready_mem_wb = 1'b1; // WB never refuses the MEM stage.

	wb_stage stage0 (
		.clk, .rst,
		.valid_mem_wb, .advance,
		.pc_mem_wb, .inst_mem_wb, .op_class_mem_wb, .rd_mem_wb,
		.wr_value, .raddr, .waddr,
		.commit, .gpr_wen, .wb_rd, .wb_wdata,
		.wb_pc, .wb_inst, .wb_op_class, .wb_raddr, .wb_waddr
	);

	gpr_file gprs0 (
		.clk, .rst,
		.gpr_wen, .wb_rd, .wb_wdata,
		.rd_a_idx, .rd_b_idx, .rd_a_val, .rd_b_val,
		.trace_rs1_idx, .trace_rs1_val
	);

	commit_tracer tracer0 (
		.clk, .rst,
		.commit, .wb_pc, .wb_inst, .wb_op_class, .wb_raddr, .wb_waddr,
		.trace_rs1_idx, .trace_rs1_val,
		.retired_count, .load_count, .store_count,
		.jump_valid, .jump_pc, .jump_target,
		.mem_valid, .mem_kind, .mem_addr
	);

endmodule

//--- hw/commit_tracer.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module commit_tracer
	import wb_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	// committed instruction from WB.
	input  logic      commit,
	input  xlen_t     wb_pc,
	input  inst_t     wb_inst,
	input  op_class_t wb_op_class,
	input  xlen_t     wb_raddr,
	input  xlen_t     wb_waddr,

	// rs1 lookup for jalr.
	output reg_idx_t  trace_rs1_idx,
	input  xlen_t     trace_rs1_val,

	output count_t    retired_count,
	output count_t    load_count,
	output count_t    store_count,

	output logic      jump_valid,
	output xlen_t     jump_pc,
	output xlen_t     jump_target,

	output logic      mem_valid,
	output mem_kind_t mem_kind,
	output xlen_t     mem_addr
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	xlen_t      imm_i;
	xlen_t      imm_j;
	xlen_t      target_now;
	logic       is_jump;
	mem_kind_t  kind_now;
	xlen_t      addr_now;

	assign opcode        = wb_inst[6:0];
	assign funct3        = wb_inst[14:12];
	assign trace_rs1_idx = wb_inst[19:15];

	assign imm_i = {{52{wb_inst[31]}}, wb_inst[31:20]};
	assign imm_j = {{43{wb_inst[31]}}, wb_inst[31], wb_inst[19:12],
		wb_inst[20], wb_inst[30:21], 1'b0};

	assign is_jump = wb_op_class[`OPC_JAL] | wb_op_class[`OPC_JALR];

	// jalr clears bit 0 of the sum.
	assign target_now = wb_op_class[`OPC_JAL] ? (wb_pc + imm_j) :
		((trace_rs1_val + imm_i) & ~64'd1);

	// lb..lwu are funct3 0..6, sb..sd are 0..3.
	always_comb begin
		kind_now = MEM_NONE;
		addr_now = wb_raddr;
		if (opcode == `RV_OP_LOAD && funct3 != 3'd7) begin
			kind_now = MEM_LOAD;
		end else if (opcode == `RV_OP_STORE && !funct3[2]) begin
			kind_now = MEM_STORE;
			addr_now = wb_waddr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			retired_count <= '0;
			load_count    <= '0;
			store_count   <= '0;
			jump_valid    <= 1'b0;
			mem_valid     <= 1'b0;
			mem_kind      <= MEM_NONE;
		end else begin
			jump_valid <= commit & is_jump; // one-cycle strobes.
			mem_valid  <= commit & (kind_now != MEM_NONE);
			if (commit) begin
				retired_count <= retired_count + 1'b1;
				mem_kind      <= kind_now;
				if (kind_now == MEM_LOAD) begin
					load_count <= load_count + 1'b1;
				end
				if (kind_now == MEM_STORE) begin
					store_count <= store_count + 1'b1;
				end
			end
		end
	end

	// trace payload, only meaningful with its strobe.
	always_ff @(posedge clk) begin
		if (commit && is_jump) begin
			jump_pc     <= wb_pc;
			jump_target <= target_now;
		end
		if (commit && kind_now != MEM_NONE) begin
			mem_addr <= addr_now;
		end
	end

endmodule

//--- hw/gpr_file.sv
`timescale 1ns/1ps

module gpr_file
	import wb_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	// write port from WB.
	input  logic     gpr_wen,
	input  reg_idx_t wb_rd,
	input  xlen_t    wb_wdata,

	// external read ports, forwarding the write in flight.
	input  reg_idx_t rd_a_idx,
	input  reg_idx_t rd_b_idx,
	output xlen_t    rd_a_val,
	output xlen_t    rd_b_val,

	// tracer port, stored value only.
	input  reg_idx_t trace_rs1_idx,
	output xlen_t    trace_rs1_val
);

	localparam int num_gpr = 1 << $bits(reg_idx_t);

	xlen_t regs [num_gpr];

	// forward a pending write, x0 never forwards.
	function automatic xlen_t fwd_read(input reg_idx_t idx, input xlen_t stored);
		xlen_t val;
		val = stored;
		if (idx == '0) begin
			val = '0;
		end else if (gpr_wen && wb_rd == idx) begin
			val = wb_wdata;
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_gpr; i++) begin
				regs[i] <= '0;
			end
		end else if (gpr_wen && wb_rd != '0) begin
			regs[wb_rd] <= wb_wdata; // x0 stays zero.
		end
	end

	assign rd_a_val = fwd_read(rd_a_idx, regs[rd_a_idx]);
	assign rd_b_val = fwd_read(rd_b_idx, regs[rd_b_idx]);

	// earlier results are already stored one edge before.
	assign trace_rs1_val = regs[trace_rs1_idx];

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module wb_stage
	import wb_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	// from the MEM stage.
	input  logic      valid_mem_wb,
	input  logic      advance,
	input  xlen_t     pc_mem_wb,
	input  inst_t     inst_mem_wb,
	input  op_class_t op_class_mem_wb,
	input  reg_idx_t  rd_mem_wb,
	input  xlen_t     wr_value,
	input  xlen_t     raddr,
	input  xlen_t     waddr,

	// register file write side.
	output logic      commit,
	output logic      gpr_wen,
	output reg_idx_t  wb_rd,
	output xlen_t     wb_wdata,

	// to the tracer.
	output xlen_t     wb_pc,
	output inst_t     wb_inst,
	output op_class_t wb_op_class,
	output xlen_t     wb_raddr,
	output xlen_t     wb_waddr
);

	// classes that write a destination register.
	localparam op_class_t wr_mask = op_class_t'(
		(1 << `OPC_LUI)   |
		(1 << `OPC_AUIPC) |
		(1 << `OPC_JAL)   |
		(1 << `OPC_JALR)  |
		(1 << `OPC_LOAD)  |
		(1 << `OPC_ALUI)  |
		(1 << `OPC_ALU)   |
		(1 << `OPC_ALUIW) |
		(1 << `OPC_ALUW)  |
		(1 << `OPC_CSR)
	);

	logic wb_valid;  // an instruction sits in WB.
	logic writes_rd; // its class writes rd.

	// valid bit is the only control state in the stage.
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else if (advance) begin
			wb_valid <= valid_mem_wb;
		end
	end

	// payload follows the valid bit and holds while stalled.
	always_ff @(posedge clk) begin
		if (advance) begin
			wb_pc       <= pc_mem_wb;
			wb_inst     <= inst_mem_wb;
			wb_op_class <= op_class_mem_wb;
			wb_rd       <= rd_mem_wb;
			wb_wdata    <= wr_value;
			wb_raddr    <= raddr;
			wb_waddr    <= waddr;
		end
	end

	// retire only when downstream takes the instruction.
	assign commit = wb_valid & advance;

	assign writes_rd = |(wb_op_class & wr_mask);

	// x0 is filtered inside the register file.
	assign gpr_wen = commit & writes_rd;

endmodule

//--- hw/wb_pkg.sv
`include "wb_consts.svh"

package wb_pkg;

	// data words, pc, jump targets and memory addresses.
	typedef logic [63:0] xlen_t;

	typedef logic [31:0] inst_t; // raw instruction word.

	typedef logic [4:0] reg_idx_t; // gpr index.

	// one-hot class vector, see OPC_* for bit meanings.
	typedef logic [14:0] op_class_t;

	typedef logic [`WB_COUNT_W-1:0] count_t; // event counters.

	// kind of a memory trace event.
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_kind_t;

endpackage

//--- hw/wb_consts.svh
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// bit positions in the one-hot op class vector from decode.
`define OPC_LUI     0
`define OPC_AUIPC   1
`define OPC_JAL     2
`define OPC_JALR    3
`define OPC_BRANCH  4
`define OPC_LOAD    5
`define OPC_STORE   6
`define OPC_ALUI    7
`define OPC_ALU     8
`define OPC_ALUIW   9
`define OPC_ALUW    10
`define OPC_CSR     11 // bits 12..14 reserved.

`define RV_OP_LOAD  7'b0000011 // major opcodes.
`define RV_OP_STORE 7'b0100011

`define WB_NUM_GPR  32
`define WB_COUNT_W  32

`endif
